// File: verilog/icm_params.svh
//-------------------------------------------------
// icm entry gathering engine
// widths and depths shared by the RTL
//-------------------------------------------------

`ifndef ICM_PARAMS_SVH
`define ICM_PARAMS_SVH

// request tags, one reorder slot each
`define ICM_TAG_NUM 8
`define ICM_TAG_W 3

// icm address and cache entry
`define ICM_ADDR_W 16
`define ICM_ENTRY_W 32

// piece counts, at most two pieces per request
`define ICM_COUNT_W 2

// completion fifo depth, equal to the credit count
`define ICM_CPL_DEPTH 4

`endif

// File: verilog/icm_req_pkg.sv
//-------------------------------------------------
// icm request formats
// request head, cache entry and slot piece
//-------------------------------------------------

`default_nettype none

`include "icm_params.svh"

package icm_req_pkg;

    // request head as carried by both queues, 23 bits
    typedef struct packed {
        logic [`ICM_COUNT_W-1:0] count_max;
        logic [`ICM_COUNT_W-1:0] count_index;
        logic [`ICM_TAG_W-1:0]   tag;
        logic [`ICM_ADDR_W-1:0]  addr;
    } req_head_t;

    // one cache entry
    typedef logic [`ICM_ENTRY_W-1:0] entry_t;

    // head plus entry, as written into a slot
    typedef struct packed {
        req_head_t head;
        entry_t    data;
    } piece_t;

endpackage

`default_nettype wire

// File: verilog/icm_ctrl_pkg.sv
//-------------------------------------------------
// icm controller states
// collector and response streamer FSMs
//-------------------------------------------------

`default_nettype none

package icm_ctrl_pkg;

    typedef enum logic [1:0] {
        COL_IDLE,
        COL_HIT,
        COL_SET,
        COL_CPL_WAIT
    } collect_state_e;

    typedef enum logic {
        STR_IDLE,
        STR_BEAT
    } stream_state_e;

endpackage

`default_nettype wire

// File: verilog/reorder_slot_if.sv
//-------------------------------------------------
// reorder slot interfaces
// write side for the collector, read side for
// the response streamer
//-------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "icm_params.svh"

interface slot_write_if;
    logic                    wen;
    logic [`ICM_TAG_W-1:0]   tag;
    logic [`ICM_COUNT_W-1:0] index;
    logic [`ICM_ADDR_W-1:0]  addr;
    icm_req_pkg::entry_t     data;
    // pieces already held for tag
    logic [`ICM_COUNT_W-1:0] collected;

    modport collector (output wen, tag, index, addr, data, input collected);
    modport store (input wen, tag, index, addr, data, output collected);
endinterface

interface slot_read_if;
    logic                    clear;
    logic [`ICM_TAG_W-1:0]   tag;
    logic [`ICM_COUNT_W-1:0] index;
    logic [`ICM_ADDR_W-1:0]  addr;
    icm_req_pkg::entry_t     data;

    modport streamer (output clear, tag, index, input addr, data);
    modport store (input clear, tag, index, output addr, data);
endinterface

`default_nettype wire

// File: verilog/icm_entry_collector.sv
//-------------------------------------------------
// icm entry collector
// takes hit and miss pieces, writes them into the
// reorder slots, forwards miss entries to the
// cache and posts completions under credit
//-------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "icm_params.svh"

module icm_entry_collector (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          hit_valid,
    input  icm_req_pkg::req_head_t       hit_head,
    input  icm_req_pkg::entry_t          hit_data,
    output logic                         hit_ready,
    input  wire                          miss_valid,
    input  icm_req_pkg::req_head_t       miss_head,
    output logic                         miss_ready,
    input  wire                          mem_valid,
    input  icm_req_pkg::entry_t          mem_data,
    output logic                         mem_ready,
    output logic                         set_valid,
    output logic [`ICM_ADDR_W-1:0]       set_addr,
    output icm_req_pkg::entry_t          set_data,
    input  wire                          set_ready,
    output logic                         cpl_valid,
    output logic [`ICM_TAG_W-1:0]        cpl_tag,
    output logic [`ICM_COUNT_W-1:0]      cpl_total,
    input  wire                          credit,
    slot_write_if.collector              slot
);

    icm_ctrl_pkg::collect_state_e state_q;
    icm_ctrl_pkg::collect_state_e state_d;
    icm_req_pkg::piece_t piece;
    logic [$clog2(`ICM_CPL_DEPTH+1)-1:0] credit_q;
    logic write_fire;
    logic piece_done;

    // the piece in flight comes from the miss side only in SET
    always_comb begin
        if (state_q == icm_ctrl_pkg::COL_SET) begin
            piece.head = miss_head;
            piece.data = mem_data;
        end else begin
            piece.head = hit_head;
            piece.data = hit_data;
        end
    end

    assign hit_ready  = (state_q == icm_ctrl_pkg::COL_HIT);
    assign set_valid  = (state_q == icm_ctrl_pkg::COL_SET);
    assign set_addr   = miss_head.addr;
    assign set_data   = mem_data;
    // miss entry leaves both queues once the cache takes it
    assign miss_ready = set_valid && set_ready;
    assign mem_ready  = set_valid && set_ready;

    assign write_fire  = hit_ready || miss_ready;
    assign slot.wen    = write_fire;
    assign slot.tag    = piece.head.tag;
    assign slot.index  = piece.head.count_index;
    assign slot.addr   = piece.head.addr;
    assign slot.data   = piece.data;
    assign piece_done  = (slot.collected + 2'd1) == piece.head.count_max;

    assign cpl_valid = (state_q == icm_ctrl_pkg::COL_CPL_WAIT) && (credit_q != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icm_ctrl_pkg::COL_IDLE: begin
                // miss with its memory entry wins over a hit
                if (miss_valid && mem_valid) begin
                    state_d = icm_ctrl_pkg::COL_SET;
                end else if (hit_valid) begin
                    state_d = icm_ctrl_pkg::COL_HIT;
                end
            end
            icm_ctrl_pkg::COL_HIT,
            icm_ctrl_pkg::COL_SET: begin
                if (write_fire) begin
                    state_d = piece_done ? icm_ctrl_pkg::COL_CPL_WAIT : icm_ctrl_pkg::COL_IDLE;
                end
            end
            icm_ctrl_pkg::COL_CPL_WAIT: begin
                if (cpl_valid) begin
                    state_d = icm_ctrl_pkg::COL_IDLE;
                end
            end
            default: state_d = icm_ctrl_pkg::COL_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= icm_ctrl_pkg::COL_IDLE;
            credit_q <= `ICM_CPL_DEPTH;
        end else begin
            state_q <= state_d;
            if (cpl_valid && !credit) begin
                credit_q <= credit_q - 1'b1;
            end else if (!cpl_valid && credit) begin
                credit_q <= credit_q + 1'b1;
            end
        end
    end

    // completion payload held until the credit shows up
    always_ff @(posedge clk) begin
        if (write_fire && piece_done) begin
            cpl_tag   <= piece.head.tag;
            cpl_total <= piece.head.count_max;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
//-------------------------------------------------
// reorder buffer
// one slot per tag with a piece count and two
// address and entry pairs
//-------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "icm_params.svh"

module reorder_buffer (
    input  wire          clk,
    input  wire          rst,
    slot_write_if.store  wr,
    slot_read_if.store   rd
);

    logic [`ICM_COUNT_W-1:0] count_q [`ICM_TAG_NUM];
    logic [`ICM_ADDR_W-1:0]  addr_q  [`ICM_TAG_NUM][2];
    icm_req_pkg::entry_t     data_q  [`ICM_TAG_NUM][2];

    assign wr.collected = count_q[wr.tag];
    assign rd.addr      = addr_q[rd.tag][rd.index[0]];
    assign rd.data      = data_q[rd.tag][rd.index[0]];

    // write and clear never hit the same tag in one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ICM_TAG_NUM; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            if (wr.wen) begin
                count_q[wr.tag] <= count_q[wr.tag] + 2'd1;
            end
            if (rd.clear) begin
                count_q[rd.tag] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wen) begin
            addr_q[wr.tag][wr.index[0]] <= wr.addr;
            data_q[wr.tag][wr.index[0]] <= wr.data;
        end
        if (rd.clear) begin
            addr_q[rd.tag][0] <= '0;
            addr_q[rd.tag][1] <= '0;
            data_q[rd.tag][0] <= '0;
            data_q[rd.tag][1] <= '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/response_streamer.sv
//-------------------------------------------------
// response streamer
// queues completions and streams one beat per
// piece in index order, then frees the slot
//-------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "icm_params.svh"

module response_streamer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cpl_valid,
    input  wire  [`ICM_TAG_W-1:0]        cpl_tag,
    input  wire  [`ICM_COUNT_W-1:0]      cpl_total,
    output logic                         credit,
    output logic                         rsp_valid,
    output logic [`ICM_TAG_W-1:0]        rsp_tag,
    output logic [`ICM_COUNT_W-1:0]      rsp_index,
    output logic [`ICM_ADDR_W-1:0]       rsp_addr,
    output icm_req_pkg::entry_t          rsp_data,
    input  wire                          rsp_ready,
    slot_read_if.streamer                slot
);

    icm_ctrl_pkg::stream_state_e state_q;
    logic [`ICM_TAG_W-1:0]   fifo_tag   [`ICM_CPL_DEPTH];
    logic [`ICM_COUNT_W-1:0] fifo_total [`ICM_CPL_DEPTH];
    logic [$clog2(`ICM_CPL_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(`ICM_CPL_DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(`ICM_CPL_DEPTH+1)-1:0] fill_q;
    logic [`ICM_TAG_W-1:0]   cur_tag_q;
    logic [`ICM_COUNT_W-1:0] cur_total_q;
    logic [`ICM_COUNT_W-1:0] beat_idx_q;
    logic fifo_empty;
    logic pop;
    logic last_beat;

    assign fifo_empty = (fill_q == '0);
    // empty fifo passes a fresh completion straight through
    assign pop = (state_q == icm_ctrl_pkg::STR_IDLE) && (!fifo_empty || cpl_valid);

    assign rsp_valid  = (state_q == icm_ctrl_pkg::STR_BEAT);
    assign rsp_tag    = cur_tag_q;
    assign rsp_index  = beat_idx_q;
    assign rsp_addr   = slot.addr;
    assign rsp_data   = slot.data;
    assign slot.tag   = cur_tag_q;
    assign slot.index = beat_idx_q;

    assign last_beat  = (beat_idx_q == cur_total_q - 2'd1);
    assign credit     = rsp_valid && rsp_ready && last_beat;
    assign slot.clear = credit;

    // completion storage, always written on push
    always_ff @(posedge clk) begin
        if (cpl_valid) begin
            fifo_tag[wr_ptr_q]   <= cpl_tag;
            fifo_total[wr_ptr_q] <= cpl_total;
        end
        if (pop) begin
            cur_tag_q   <= fifo_empty ? cpl_tag : fifo_tag[rd_ptr_q];
            cur_total_q <= fifo_empty ? cpl_total : fifo_total[rd_ptr_q];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= icm_ctrl_pkg::STR_IDLE;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fill_q     <= '0;
            beat_idx_q <= '0;
        end else begin
            if (cpl_valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (cpl_valid && !pop) begin
                fill_q <= fill_q + 1'b1;
            end else if (!cpl_valid && pop) begin
                fill_q <= fill_q - 1'b1;
            end
            if (pop) begin
                state_q    <= icm_ctrl_pkg::STR_BEAT;
                beat_idx_q <= '0;
            end else if (credit) begin
                state_q <= icm_ctrl_pkg::STR_IDLE;
            end else if (rsp_valid && rsp_ready) begin
                beat_idx_q <= beat_idx_q + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/icm_get_proc.sv
//-------------------------------------------------
// icm get processing top
// collector, reorder buffer and response streamer
//-------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "icm_params.svh"

module icm_get_proc (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          hit_valid,
    input  icm_req_pkg::req_head_t       hit_head,
    input  icm_req_pkg::entry_t          hit_data,
    output wire                          hit_ready,
    input  wire                          miss_valid,
    input  icm_req_pkg::req_head_t       miss_head,
    output wire                          miss_ready,
    input  wire                          mem_valid,
    input  icm_req_pkg::entry_t          mem_data,
    output wire                          mem_ready,
    output wire                          set_valid,
    output wire  [`ICM_ADDR_W-1:0]       set_addr,
    output icm_req_pkg::entry_t          set_data,
    input  wire                          set_ready,
    output wire                          rsp_valid,
    output wire  [`ICM_TAG_W-1:0]        rsp_tag,
    output wire  [`ICM_COUNT_W-1:0]      rsp_index,
    output wire  [`ICM_ADDR_W-1:0]       rsp_addr,
    output icm_req_pkg::entry_t          rsp_data,
    input  wire                          rsp_ready
);

    // completion channel between collector and streamer
    wire                     cpl_valid;
    wire [`ICM_TAG_W-1:0]    cpl_tag;
    wire [`ICM_COUNT_W-1:0]  cpl_total;
    wire                     credit;

    slot_write_if wr_if ();
    slot_read_if  rd_if ();

    icm_entry_collector u_collector (
        .clk        (clk),
        .rst        (rst),
        .hit_valid  (hit_valid),
        .hit_head   (hit_head),
        .hit_data   (hit_data),
        .hit_ready  (hit_ready),
        .miss_valid (miss_valid),
        .miss_head  (miss_head),
        .miss_ready (miss_ready),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .mem_ready  (mem_ready),
        .set_valid  (set_valid),
        .set_addr   (set_addr),
        .set_data   (set_data),
        .set_ready  (set_ready),
        .cpl_valid  (cpl_valid),
        .cpl_tag    (cpl_tag),
        .cpl_total  (cpl_total),
        .credit     (credit),
        .slot       (wr_if.collector)
    );

    reorder_buffer u_reorder (
        .clk (clk),
        .rst (rst),
        .wr  (wr_if.store),
        .rd  (rd_if.store)
    );

    response_streamer u_streamer (
        .clk       (clk),
        .rst       (rst),
        .cpl_valid (cpl_valid),
        .cpl_tag   (cpl_tag),
        .cpl_total (cpl_total),
        .credit    (credit),
        .rsp_valid (rsp_valid),
        .rsp_tag   (rsp_tag),
        .rsp_index (rsp_index),
        .rsp_addr  (rsp_addr),
        .rsp_data  (rsp_data),
        .rsp_ready (rsp_ready),
        .slot      (rd_if.streamer)
    );

endmodule

`default_nettype wire

// File: testbench/tb_icm_get_proc.sv
//-------------------------------------------------
// testbench for the icm get processing top
// table driven hit and miss pieces, reference
// model of response beats and cache set requests
//-------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "icm_params.svh"

module tb_icm_get_proc;

    typedef struct packed {
        bit                      miss;
        logic [`ICM_TAG_W-1:0]   tag;
        logic [`ICM_COUNT_W-1:0] count_max;
        logic [`ICM_COUNT_W-1:0] count_index;
        logic [`ICM_ADDR_W-1:0]  addr;
        logic [`ICM_ENTRY_W-1:0] data;
    } row_t;

    typedef struct packed {
        logic [`ICM_TAG_W-1:0]   tag;
        logic [`ICM_COUNT_W-1:0] index;
        logic [`ICM_ADDR_W-1:0]  addr;
        logic [`ICM_ENTRY_W-1:0] data;
    } beat_t;

    logic clk;
    logic rst;
    logic hit_valid;
    icm_req_pkg::req_head_t hit_head;
    icm_req_pkg::entry_t hit_data;
    logic hit_ready;
    logic miss_valid;
    icm_req_pkg::req_head_t miss_head;
    logic miss_ready;
    logic mem_valid;
    icm_req_pkg::entry_t mem_data;
    logic mem_ready;
    logic set_valid;
    logic [`ICM_ADDR_W-1:0] set_addr;
    icm_req_pkg::entry_t set_data;
    logic set_ready;
    logic rsp_valid;
    logic [`ICM_TAG_W-1:0] rsp_tag;
    logic [`ICM_COUNT_W-1:0] rsp_index;
    logic [`ICM_ADDR_W-1:0] rsp_addr;
    icm_req_pkg::entry_t rsp_data;
    logic rsp_ready;

    // stimulus table
    row_t  rows_q[$];
    string row_name_q[$];

    // reference model state per tag
    logic [`ICM_ADDR_W-1:0]  m_addr [`ICM_TAG_NUM][2];
    logic [`ICM_ENTRY_W-1:0] m_data [`ICM_TAG_NUM][2];
    int got [`ICM_TAG_NUM];
    int pending [`ICM_TAG_NUM];
    beat_t exp_beat_q[$];
    string exp_name_q[$];
    beat_t exp_set_q[$];
    string exp_set_name_q[$];

    int cycles = 0;
    int cycle_limit = 200;
    int stall_until = 0;
    int miss_rows = 0;
    int set_count = 0;

    icm_get_proc u_dut (
        .clk        (clk),
        .rst        (rst),
        .hit_valid  (hit_valid),
        .hit_head   (hit_head),
        .hit_data   (hit_data),
        .hit_ready  (hit_ready),
        .miss_valid (miss_valid),
        .miss_head  (miss_head),
        .miss_ready (miss_ready),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .mem_ready  (mem_ready),
        .set_valid  (set_valid),
        .set_addr   (set_addr),
        .set_data   (set_data),
        .set_ready  (set_ready),
        .rsp_valid  (rsp_valid),
        .rsp_tag    (rsp_tag),
        .rsp_index  (rsp_index),
        .rsp_addr   (rsp_addr),
        .rsp_data   (rsp_data),
        .rsp_ready  (rsp_ready)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("mismatch %s expected %0h actual %0h",
                                     name, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input bit miss,
                           input logic [`ICM_TAG_W-1:0] tag,
                           input logic [`ICM_COUNT_W-1:0] count_max,
                           input logic [`ICM_COUNT_W-1:0] count_index,
                           input logic [`ICM_ADDR_W-1:0] addr,
                           input logic [`ICM_ENTRY_W-1:0] data);
        row_t r;
        r = '{miss, tag, count_max, count_index, addr, data};
        rows_q.push_back(r);
        row_name_q.push_back(name);
    endtask

    function automatic icm_req_pkg::req_head_t make_head(input row_t r);
        icm_req_pkg::req_head_t h;
        h.count_max   = r.count_max;
        h.count_index = r.count_index;
        h.tag         = r.tag;
        h.addr        = r.addr;
        return h;
    endfunction

    // miss rows drive the miss queue and memory stream together
    task automatic drive_row(input row_t r, input string name);
        beat_t set_exp;
        if (r.miss) begin
            miss_valid <= 1'b1;
            miss_head  <= make_head(r);
            mem_valid  <= 1'b1;
            mem_data   <= r.data;
            set_exp = '{r.tag, r.count_index, r.addr, r.data};
            exp_set_q.push_back(set_exp);
            exp_set_name_q.push_back(name);
            miss_rows = miss_rows + 1;
        end else begin
            hit_valid <= 1'b1;
            hit_head  <= make_head(r);
            hit_data  <= r.data;
        end
    endtask

    // ready seen at negedge means the transfer happens at the next edge
    task automatic wait_accept(input bit miss);
        logic ready;
        ready = 1'b0;
        while (!ready) begin
            @(negedge clk);
            ready = miss ? (miss_ready && mem_ready) : hit_ready;
        end
        @(posedge clk);
    endtask

    task automatic release_inputs();
        hit_valid  <= 1'b0;
        miss_valid <= 1'b0;
        mem_valid  <= 1'b0;
    endtask

    // a completed tag expects its beats in index order
    task automatic record_piece(input row_t r, input string name);
        beat_t beat;
        m_addr[r.tag][r.count_index[0]] = r.addr;
        m_data[r.tag][r.count_index[0]] = r.data;
        got[r.tag] = got[r.tag] + 1;
        if (got[r.tag] == int'(r.count_max)) begin
            for (int b = 0; b < int'(r.count_max); b++) begin
                beat = '{r.tag, 2'(b), m_addr[r.tag][b], m_data[r.tag][b]};
                exp_beat_q.push_back(beat);
                exp_name_q.push_back(name);
            end
            pending[r.tag] = int'(r.count_max);
            got[r.tag] = 0;
        end
    endtask

    task automatic load_table();
        add_row("one_hit",      1'b0, 3'd0, 2'd1, 2'd0, 16'h1000, 32'ha000_0001);
        add_row("one_miss",     1'b1, 3'd1, 2'd1, 2'd0, 16'h1010, 32'ha000_0002);
        add_row("mixed_pair",   1'b0, 3'd2, 2'd2, 2'd1, 16'h2021, 32'hb000_0021);
        add_row("mixed_pair",   1'b1, 3'd2, 2'd2, 2'd0, 16'h2020, 32'hb000_0020);
        add_row("interleave",   1'b0, 3'd3, 2'd2, 2'd0, 16'h3030, 32'hc000_0030);
        add_row("interleave",   1'b1, 3'd4, 2'd1, 2'd0, 16'h3040, 32'hc000_0040);
        add_row("interleave",   1'b1, 3'd5, 2'd2, 2'd1, 16'h3051, 32'hc000_0051);
        add_row("interleave",   1'b1, 3'd3, 2'd2, 2'd1, 16'h3031, 32'hc000_0031);
        add_row("interleave",   1'b0, 3'd5, 2'd2, 2'd0, 16'h3050, 32'hc000_0050);
        add_row("interleave",   1'b0, 3'd6, 2'd1, 2'd0, 16'h3060, 32'hc000_0060);
        add_row("backpressure", 1'b0, 3'd7, 2'd1, 2'd0, 16'h4070, 32'hd000_0070);
        add_row("backpressure", 1'b1, 3'd0, 2'd1, 2'd0, 16'h4000, 32'hd000_0000);
        add_row("backpressure", 1'b0, 3'd1, 2'd1, 2'd0, 16'h4010, 32'hd000_0010);
        add_row("backpressure", 1'b1, 3'd2, 2'd1, 2'd0, 16'h4020, 32'hd000_0020);
        add_row("backpressure", 1'b0, 3'd4, 2'd2, 2'd1, 16'h4041, 32'hd000_0041);
        add_row("backpressure", 1'b0, 3'd4, 2'd2, 2'd0, 16'h4040, 32'hd000_0040);
        add_row("backpressure", 1'b1, 3'd3, 2'd1, 2'd0, 16'h4030, 32'hd000_0030);
        add_row("backpressure", 1'b0, 3'd5, 2'd1, 2'd0, 16'h4050, 32'hd000_0050);
        add_row("reuse",        1'b1, 3'd2, 2'd2, 2'd0, 16'h5020, 32'he000_0020);
        add_row("reuse",        1'b0, 3'd2, 2'd2, 2'd1, 16'h5021, 32'he000_0021);
        add_row("reuse",        1'b1, 3'd7, 2'd1, 2'd0, 16'h5070, 32'he000_0070);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random back-pressure and a stall window on rsp_ready
    always @(posedge clk) begin
        set_ready <= ($urandom % 4) != 0;
        rsp_ready <= (cycles < stall_until) ? 1'b0 : (($urandom % 4) != 0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            report_failure($sformatf("timeout after %0d cycles waiting for the DUT", cycles));
        end
    end

    always @(negedge clk) begin : monitor
        beat_t exp;
        string name;
        if (!rst && rsp_valid && rsp_ready) begin
            if (exp_beat_q.size() == 0) begin
                report_failure("response beat arrived with no completed request");
            end else begin
                exp  = exp_beat_q.pop_front();
                name = exp_name_q.pop_front();
                check_value({name, " rsp_tag"}, 64'(exp.tag), 64'(rsp_tag));
                check_value({name, " rsp_index"}, 64'(exp.index), 64'(rsp_index));
                check_value({name, " rsp_addr"}, 64'(exp.addr), 64'(rsp_addr));
                check_value({name, " rsp_data"}, 64'(exp.data), 64'(rsp_data));
                pending[exp.tag] = pending[exp.tag] - 1;
            end
        end
        if (!rst && set_valid && set_ready) begin
            if (exp_set_q.size() == 0) begin
                report_failure("cache set request issued with no miss pending");
            end else begin
                exp  = exp_set_q.pop_front();
                name = exp_set_name_q.pop_front();
                check_value({name, " set_addr"}, 64'(exp.addr), 64'(set_addr));
                check_value({name, " set_data"}, 64'(exp.data), 64'(set_data));
                set_count = set_count + 1;
            end
        end
    end

    initial begin
        row_t row;
        bit stalled;
        void'($urandom(32'h9db6));
        stalled    = 1'b0;
        rst        = 1'b1;
        hit_valid  = 1'b0;
        hit_head   = '0;
        hit_data   = '0;
        miss_valid = 1'b0;
        miss_head  = '0;
        mem_valid  = 1'b0;
        mem_data   = '0;
        set_ready  = 1'b0;
        rsp_ready  = 1'b0;
        for (int t = 0; t < `ICM_TAG_NUM; t++) begin
            got[t]     = 0;
            pending[t] = 0;
        end
        load_table();
        cycle_limit = 40 * rows_q.size() + 200;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < rows_q.size(); r++) begin
            row = rows_q[r];
            // a new request waits until its tag has drained
            if (got[row.tag] == 0) begin
                while (pending[row.tag] != 0) @(negedge clk);
            end
            if (row_name_q[r] == "backpressure" && !stalled) begin
                stall_until = cycles + 60;
                stalled = 1'b1;
            end
            @(posedge clk);
            drive_row(row, row_name_q[r]);
            wait_accept(row.miss);
            release_inputs();
            record_piece(row, row_name_q[r]);
        end

        while (exp_beat_q.size() != 0) @(negedge clk);
        // idle stretch to catch stray beats
        repeat (20) @(negedge clk);
        if (set_count == miss_rows) begin
            $display("All checks passed");
            $finish;
        end else begin
            check_value("miss write-back count", 64'(miss_rows), 64'(set_count));
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/icm_req_pkg.sv
verilog/icm_ctrl_pkg.sv
verilog/reorder_slot_if.sv
verilog/icm_entry_collector.sv
verilog/reorder_buffer.sv
verilog/response_streamer.sv
verilog/icm_get_proc.sv
testbench/tb_icm_get_proc.sv

// File: run.sh
#!/bin/sh
# build and run the icm get processing testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --top-module tb_icm_get_proc -f list.f -o sim_icm
./obj_dir/sim_icm > sim.log 2>&1 || true
cat sim.log
if grep -q "All checks passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
